/* source/board_io_config.svh */
`ifndef BOARD_IO_CONFIG_SVH
`define BOARD_IO_CONFIG_SVH

// Register map, byte offsets on the AXI4-Lite port
`define BOARD_REG_DISP 4'h0
`define BOARD_REG_LED 4'h4
`define BOARD_REG_CMP 4'h8
`define BOARD_REG_CNT 4'hC

// Count enable lives just above the LED bits
`define BOARD_CTRL_BIT 13
`define BOARD_LED_BITS 13

// Clocks per displayed digit
`define BOARD_SCAN_DIV 6

`define BOARD_RESP_OKAY 2'b00
`define BOARD_RESP_SLVERR 2'b10

`define BOARD_DATA_W 32
`define BOARD_ADDR_W 4
`define BOARD_LED_W 16
`define BOARD_DIGITS 8

`endif

/* source/board_io_pkg.sv */
`include "board_io_config.svh"

package board_io_pkg;

  typedef logic [`BOARD_DATA_W-1:0] word_t;
  typedef logic [`BOARD_ADDR_W-1:0] reg_addr_t;
  typedef logic [`BOARD_DATA_W/8-1:0] strb_t;
  typedef logic [1:0] resp_t;
  typedef logic [3:0] nibble_t;
  // Active low, segment a in the top bit
  typedef logic [6:0] seg_t;
  typedef logic [`BOARD_DIGITS-1:0] anode_t;
  typedef logic [`BOARD_LED_W-1:0] led_t;

  // One-hot-low anode rotation
  typedef enum anode_t {
    digit_0 = 8'b1111_1110,
    digit_1 = 8'b1111_1101,
    digit_2 = 8'b1111_1011,
    digit_3 = 8'b1111_0111,
    digit_4 = 8'b1110_1111,
    digit_5 = 8'b1101_1111,
    digit_6 = 8'b1011_1111,
    digit_7 = 8'b0111_1111
  } digit_e;

  typedef struct packed {
    word_t disp_word;
    logic [`BOARD_LED_BITS-1:0] led_bits;
  } disp_cfg_t;

  typedef struct packed {
    logic enable;
    word_t compare;
    logic load;
    word_t load_value;
    logic clear_ovf;
  } cnt_ctrl_t;

  typedef struct packed {
    word_t count;
    logic match;
    logic overflow;
    logic irq;
  } cnt_stat_t;

endpackage

/* source/axil_regs.sv */
`timescale 1ns/100ps
`include "board_io_config.svh"

module axil_regs (
  input  logic                     clk,
  input  logic                     rst_n,
  // Write address and data
  input  logic                     awvalid,
  output logic                     awready,
  input  board_io_pkg::reg_addr_t  awaddr,
  input  logic                     wvalid,
  output logic                     wready,
  input  board_io_pkg::word_t      wdata,
  input  board_io_pkg::strb_t      wstrb,
  // Write response
  output logic                     bvalid,
  input  logic                     bready,
  output board_io_pkg::resp_t      bresp,
  // Read address and data
  input  logic                     arvalid,
  output logic                     arready,
  input  board_io_pkg::reg_addr_t  araddr,
  output logic                     rvalid,
  input  logic                     rready,
  output board_io_pkg::word_t      rdata,
  output board_io_pkg::resp_t      rresp,
  // Block side
  input  board_io_pkg::cnt_stat_t  cnt_stat,
  output board_io_pkg::disp_cfg_t  disp_cfg,
  output board_io_pkg::cnt_ctrl_t  cnt_ctrl
);

  board_io_pkg::word_t disp_reg;
  board_io_pkg::word_t cmp_reg;
  logic [`BOARD_CTRL_BIT:0] led_reg;
  board_io_pkg::word_t load_value;
  logic load_pulse;

  logic wr_accept;
  logic rd_accept;
  logic wr_misaligned;
  logic rd_misaligned;
  logic wr_cnt;
  board_io_pkg::word_t wr_old;
  board_io_pkg::word_t wr_merged;
  board_io_pkg::word_t rd_data;

  function automatic board_io_pkg::word_t merge_bytes(
    input board_io_pkg::word_t old_val,
    input board_io_pkg::word_t new_val,
    input board_io_pkg::strb_t strb
  );
    board_io_pkg::word_t res;
    res = old_val;
    for (int i = 0; i < $bits(strb); i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Address and data taken together only with no response pending
  assign wr_accept = awvalid && wvalid && !bvalid;
  assign awready   = wr_accept;
  assign wready    = wr_accept;
  assign rd_accept = arvalid && !rvalid;
  assign arready   = rd_accept;

  assign wr_misaligned = |awaddr[1:0];
  assign rd_misaligned = |araddr[1:0];
  assign wr_cnt = wr_accept && !wr_misaligned && (awaddr == `BOARD_REG_CNT);

  // Current value of the addressed register for the strobe merge
  always_comb begin
    case (awaddr)
      `BOARD_REG_DISP: wr_old = disp_reg;
      `BOARD_REG_LED:  wr_old = board_io_pkg::word_t'(led_reg);
      `BOARD_REG_CMP:  wr_old = cmp_reg;
      `BOARD_REG_CNT:  wr_old = cnt_stat.count;
      default:         wr_old = '0;
    endcase
  end

  assign wr_merged = merge_bytes(wr_old, wdata, wstrb);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bvalid     <= 1'b0;
      bresp      <= `BOARD_RESP_OKAY;
      disp_reg   <= '0;
      led_reg    <= '0;
      cmp_reg    <= '0;
      load_pulse <= 1'b0;
    end else begin
      load_pulse <= wr_cnt;
      if (wr_accept) begin
        bvalid <= 1'b1;
        if (wr_misaligned) begin
          bresp <= `BOARD_RESP_SLVERR;
        end else begin
          bresp <= `BOARD_RESP_OKAY;
          case (awaddr)
            `BOARD_REG_DISP: disp_reg <= wr_merged;
            `BOARD_REG_LED:  led_reg  <= wr_merged[`BOARD_CTRL_BIT:0];
            `BOARD_REG_CMP:  cmp_reg  <= wr_merged;
            default: ;
          endcase
        end
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // Count value for the load pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_value <= '0;
    end else if (wr_cnt) begin
      load_value <= wr_merged;
    end
  end

  always_comb begin
    case (araddr)
      `BOARD_REG_DISP: rd_data = disp_reg;
      `BOARD_REG_LED:  rd_data = board_io_pkg::word_t'(led_reg);
      `BOARD_REG_CMP:  rd_data = cmp_reg;
      `BOARD_REG_CNT:  rd_data = cnt_stat.count;
      default:         rd_data = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
      rdata  <= '0;
      rresp  <= `BOARD_RESP_OKAY;
    end else if (rd_accept) begin
      rvalid <= 1'b1;
      rdata  <= rd_misaligned ? '0 : rd_data;
      rresp  <= rd_misaligned ? `BOARD_RESP_SLVERR : `BOARD_RESP_OKAY;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  assign disp_cfg.disp_word = disp_reg;
  assign disp_cfg.led_bits  = led_reg[`BOARD_LED_BITS-1:0];

  // A count write both loads and clears overflow
  assign cnt_ctrl.enable     = led_reg[`BOARD_CTRL_BIT];
  assign cnt_ctrl.compare    = cmp_reg;
  assign cnt_ctrl.load       = load_pulse;
  assign cnt_ctrl.load_value = load_value;
  assign cnt_ctrl.clear_ovf  = load_pulse;

endmodule

/* source/event_counter.sv */
`timescale 1ns/100ps

module event_counter (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     event_in,
  input  board_io_pkg::cnt_ctrl_t  cnt_ctrl,
  output board_io_pkg::cnt_stat_t  cnt_stat
);

  logic sync_1;
  logic sync_2;
  logic sync_prev;
  logic bump;
  logic match;
  logic overflow;
  board_io_pkg::word_t count;

  // Two flops into the clock domain, third for the edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_1    <= 1'b0;
      sync_2    <= 1'b0;
      sync_prev <= 1'b0;
    end else begin
      sync_1    <= event_in;
      sync_2    <= sync_1;
      sync_prev <= sync_2;
    end
  end

  assign bump = cnt_ctrl.enable && sync_2 && !sync_prev;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (cnt_ctrl.load) begin
        count <= cnt_ctrl.load_value;
      end else if (bump) begin
        count <= count + 1'b1;
      end
      // Sticky until the next count write
      if (cnt_ctrl.clear_ovf) begin
        overflow <= 1'b0;
      end else if (bump && (&count)) begin
        overflow <= 1'b1;
      end
    end
  end

  // Match only while counting, so a cleared block stays quiet
  assign match = cnt_ctrl.enable && (count == cnt_ctrl.compare);

  assign cnt_stat.count    = count;
  assign cnt_stat.match    = match;
  assign cnt_stat.overflow = overflow;
  assign cnt_stat.irq      = match || overflow;

endmodule

/* source/display_driver.sv */
`timescale 1ns/100ps
`include "board_io_config.svh"

module display_driver #(
  parameter int SCAN_DIV = `BOARD_SCAN_DIV
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     debug,
  input  board_io_pkg::disp_cfg_t  disp_cfg,
  input  board_io_pkg::cnt_stat_t  cnt_stat,
  output board_io_pkg::seg_t       sev_out,
  output board_io_pkg::anode_t     an,
  output board_io_pkg::led_t       led
);

  localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

  logic [DIV_W-1:0] div_cnt;
  logic scan_tick;
  logic [2:0] nib_idx;
  board_io_pkg::word_t shown;
  board_io_pkg::nibble_t nib;
  board_io_pkg::seg_t seg_q;
  board_io_pkg::digit_e digit_q;
  board_io_pkg::digit_e digit_nxt;

  function automatic board_io_pkg::seg_t hex_to_seg(input board_io_pkg::nibble_t hex);
    case (hex)
      4'h0: return 7'b0000001;
      4'h1: return 7'b1001111;
      4'h2: return 7'b0010010;
      4'h3: return 7'b0000110;
      4'h4: return 7'b1001100;
      4'h5: return 7'b0100100;
      4'h6: return 7'b0100000;
      4'h7: return 7'b0001111;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0000100;
      4'ha: return 7'b0001000;
      4'hb: return 7'b1100000;
      4'hc: return 7'b0110001;
      4'hd: return 7'b1000010;
      4'he: return 7'b0110000;
      default: return 7'b0111000;
    endcase
  endfunction

  assign shown = debug ? cnt_stat.count : disp_cfg.disp_word;

  // Clock enable for the digit scan
  assign scan_tick = (div_cnt == DIV_W'(SCAN_DIV - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else if (scan_tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Next digit and the nibble it shows
  always_comb begin
    case (digit_q)
      board_io_pkg::digit_0: begin digit_nxt = board_io_pkg::digit_1; nib_idx = 3'd1; end
      board_io_pkg::digit_1: begin digit_nxt = board_io_pkg::digit_2; nib_idx = 3'd2; end
      board_io_pkg::digit_2: begin digit_nxt = board_io_pkg::digit_3; nib_idx = 3'd3; end
      board_io_pkg::digit_3: begin digit_nxt = board_io_pkg::digit_4; nib_idx = 3'd4; end
      board_io_pkg::digit_4: begin digit_nxt = board_io_pkg::digit_5; nib_idx = 3'd5; end
      board_io_pkg::digit_5: begin digit_nxt = board_io_pkg::digit_6; nib_idx = 3'd6; end
      board_io_pkg::digit_6: begin digit_nxt = board_io_pkg::digit_7; nib_idx = 3'd7; end
      default:               begin digit_nxt = board_io_pkg::digit_0; nib_idx = 3'd0; end
    endcase
  end

  assign nib = shown[{nib_idx, 2'b00} +: 4];

  // Segments load on the same edge as the anodes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      digit_q <= board_io_pkg::digit_0;
      seg_q   <= hex_to_seg(4'h0);
    end else if (scan_tick) begin
      digit_q <= digit_nxt;
      seg_q   <= hex_to_seg(nib);
    end
  end

  assign an      = digit_q;
  assign sev_out = seg_q;
  assign led     = {disp_cfg.led_bits, debug, cnt_stat.overflow, cnt_stat.match};

endmodule

/* source/board_io_top.sv */
`timescale 1ns/100ps
`include "board_io_config.svh"

module board_io_top (
  input  logic                     clk,
  input  logic                     rst_n,
  // AXI4-Lite slave
  input  logic                     awvalid,
  output logic                     awready,
  input  board_io_pkg::reg_addr_t  awaddr,
  input  logic                     wvalid,
  output logic                     wready,
  input  board_io_pkg::word_t      wdata,
  input  board_io_pkg::strb_t      wstrb,
  output logic                     bvalid,
  input  logic                     bready,
  output board_io_pkg::resp_t      bresp,
  input  logic                     arvalid,
  output logic                     arready,
  input  board_io_pkg::reg_addr_t  araddr,
  output logic                     rvalid,
  input  logic                     rready,
  output board_io_pkg::word_t      rdata,
  output board_io_pkg::resp_t      rresp,
  // Board pins
  input  logic                     event_in,
  input  logic                     debug,
  output board_io_pkg::seg_t       sev_out,
  output board_io_pkg::anode_t     an,
  output board_io_pkg::led_t       led,
  output logic                     irq
);

  board_io_pkg::disp_cfg_t disp_cfg;
  board_io_pkg::cnt_ctrl_t cnt_ctrl;
  board_io_pkg::cnt_stat_t cnt_stat;

  axil_regs u_regs (
    .clk, .rst_n,
    .awvalid, .awready, .awaddr,
    .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr,
    .rvalid, .rready, .rdata, .rresp,
    .cnt_stat, .disp_cfg, .cnt_ctrl
  );

  event_counter u_counter (
    .clk, .rst_n, .event_in, .cnt_ctrl, .cnt_stat
  );

  display_driver #(
    .SCAN_DIV(`BOARD_SCAN_DIV)
  ) u_display (
    .clk, .rst_n, .debug, .disp_cfg, .cnt_stat, .sev_out, .an, .led
  );

  assign irq = cnt_stat.irq;

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
  parameter int PERIOD_NS = 4,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release on a falling edge, clear of the DUT's sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* tests/board_io_sva.sv */
`timescale 1ns/100ps

module board_io_sva (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  bvalid,
  input logic                  bready,
  input board_io_pkg::resp_t   bresp,
  input logic                  rvalid,
  input logic                  rready,
  input board_io_pkg::word_t   rdata,
  input board_io_pkg::resp_t   rresp,
  input board_io_pkg::anode_t  an,
  input board_io_pkg::led_t    led,
  input logic                  irq
);

  // Responses hold until taken
  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("write response dropped or changed before bready");

  r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else $error("read response dropped or changed before rready");

  an_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(~an))
    else $error("anodes not one-hot-low");

  // led bit 1 is overflow, bit 0 is match
  irq_src: assert property (@(posedge clk) disable iff (!rst_n) irq == (led[1] || led[0]))
    else $error("irq differs from match or overflow");

endmodule

bind board_io_top board_io_sva board_io_sva_i (.*);

/* tests/board_io_tb.sv */
`timescale 1ns/100ps
`include "board_io_config.svh"

module board_io_tb;

  localparam int CLK_NS = 4;
  localparam int REG_ROUNDS = 8;
  // Rough cycle counts of the six tests plus slack
  localparam int TEST_CYC = 60 + 400 + 500 + 100 + 300 + 150;
  localparam int WATCHDOG_NS = (TEST_CYC + 500) * CLK_NS;
  localparam board_io_pkg::resp_t OKAY = `BOARD_RESP_OKAY;
  localparam board_io_pkg::resp_t SLVERR = `BOARD_RESP_SLVERR;
  // Lit segments a..g per hex digit with digit 0 in the low bits
  localparam logic [16*7-1:0] SEG_LIT = {7'h47, 7'h4F, 7'h3D, 7'h4E, 7'h1F, 7'h77,
    7'h7B, 7'h7F, 7'h70, 7'h5F, 7'h5B, 7'h33, 7'h79, 7'h6D, 7'h30, 7'h7E};

  logic clk;
  logic rst_n;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic event_in, debug, irq;
  board_io_pkg::reg_addr_t awaddr, araddr;
  board_io_pkg::word_t wdata, rdata;
  board_io_pkg::strb_t wstrb;
  board_io_pkg::resp_t bresp, rresp;
  board_io_pkg::seg_t sev_out;
  board_io_pkg::anode_t an;
  board_io_pkg::led_t led;

  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_failed = 0;
  logic [15:0] lfsr_state = 16'd31448;
  board_io_pkg::word_t model [4];
  board_io_pkg::word_t count_exp;
  logic ovf_exp;
  board_io_pkg::resp_t exp_bresp [$];
  board_io_pkg::resp_t exp_rresp [$];
  board_io_pkg::word_t exp_rdata [$];

  tb_clock #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(2)) clock_i (.clk, .rst_n);

  board_io_top dut_i (.*);

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic board_io_pkg::word_t rand_bits(input int n);
    board_io_pkg::word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Expected register contents after a write
  function automatic board_io_pkg::word_t ref_merge(input board_io_pkg::reg_addr_t a,
      input board_io_pkg::word_t old, input board_io_pkg::word_t d,
      input board_io_pkg::strb_t s);
    board_io_pkg::word_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (s[i]) res[8*i +: 8] = d[8*i +: 8];
    end
    if (a == `BOARD_REG_LED) res[31:`BOARD_CTRL_BIT+1] = '0;
    return res;
  endfunction

  function automatic board_io_pkg::seg_t seg_code(input board_io_pkg::nibble_t n);
    return ~SEG_LIT[7*n +: 7];
  endfunction

  function automatic int digit_index(input board_io_pkg::anode_t a);
    int r;
    r = -1;
    for (int i = 0; i < 8; i++) begin
      if (a == ~(board_io_pkg::anode_t'(1) << i)) r = i;
    end
    return r;
  endfunction

  function automatic logic exp_match();
    return model[1][`BOARD_CTRL_BIT] && (count_exp == model[2]);
  endfunction

  function automatic board_io_pkg::led_t exp_led(input logic dbg);
    return {model[1][`BOARD_LED_BITS-1:0], dbg, ovf_exp, exp_match()};
  endfunction

  task automatic report_mismatch(input string what, input board_io_pkg::word_t got,
      input board_io_pkg::word_t exp);
    errors++;
    $display("CHECK FAILED at %0d ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR at %0d ns: %s", $time, msg);
  endtask

  task automatic check_word(input board_io_pkg::word_t got, exp, input string what);
    checks++;
    if (got !== exp) report_mismatch(what, got, exp);
  endtask

  task automatic check_resp(input board_io_pkg::resp_t got, exp, input string what);
    checks++;
    if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
  endtask

  task automatic check_seg(input board_io_pkg::seg_t got, exp, input string what);
    checks++;
    if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
  endtask

  task automatic check_an(input board_io_pkg::anode_t got, exp, input string what);
    checks++;
    if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
  endtask

  task automatic check_led(input board_io_pkg::led_t got, exp, input string what);
    checks++;
    if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
  endtask

  task automatic check_flag(input logic got, exp, input string what);
    checks++;
    if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic start_write(input board_io_pkg::reg_addr_t a, input board_io_pkg::word_t d,
      input board_io_pkg::strb_t s);
    @(posedge clk);
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    awaddr  <= a;
    wdata   <= d;
    wstrb   <= s;
    @(negedge clk);
    while (!awready) @(negedge clk);
    check_flag(wready, 1'b1, "wready with awready");
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    // A count write loads the count and clears overflow
    if (a[1:0] == 2'b00 && a == `BOARD_REG_CNT) begin
      count_exp = ref_merge(a, count_exp, d, s);
      ovf_exp = 1'b0;
    end else if (a[1:0] == 2'b00) begin
      model[a[3:2]] = ref_merge(a, model[a[3:2]], d, s);
    end
  endtask

  task automatic finish_write();
    @(negedge clk);
    while (!(bvalid && bready)) @(negedge clk);
    @(posedge clk);
  endtask

  task automatic start_read(input board_io_pkg::reg_addr_t a);
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= a;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    arvalid <= 1'b0;
  endtask

  task automatic finish_read();
    @(negedge clk);
    while (!(rvalid && rready)) @(negedge clk);
    @(posedge clk);
  endtask

  task automatic write_reg(input board_io_pkg::reg_addr_t a, input board_io_pkg::word_t d,
      input board_io_pkg::strb_t s, input board_io_pkg::resp_t r);
    exp_bresp.push_back(r);
    start_write(a, d, s);
    finish_write();
  endtask

  task automatic read_reg(input board_io_pkg::reg_addr_t a, input board_io_pkg::word_t d,
      input board_io_pkg::resp_t r);
    exp_rdata.push_back(d);
    exp_rresp.push_back(r);
    start_read(a);
    finish_read();
  endtask

  task automatic send_pulse();
    int gap;
    gap = 2 + int'(rand_bits(2));
    @(posedge clk);
    event_in <= 1'b1;
    repeat (2) @(posedge clk);
    event_in <= 1'b0;
    repeat (gap) @(posedge clk);
    @(negedge clk);
    if (model[1][`BOARD_CTRL_BIT]) begin
      if (&count_exp) ovf_exp = 1'b1;
      count_exp = count_exp + 1;
    end
  endtask

  // Bus responses are compared here as they are taken
  always @(negedge clk) begin
    if (bvalid && bready) begin
      if (exp_bresp.size() == 0) report_error("write response arrived with none expected");
      else check_resp(bresp, exp_bresp.pop_front(), "bresp");
    end
    if (rvalid && rready) begin
      if (exp_rresp.size() == 0) begin
        report_error("read response arrived with none expected");
      end else begin
        check_resp(rresp, exp_rresp.pop_front(), "rresp");
        check_word(rdata, exp_rdata.pop_front(), "rdata");
      end
    end
  end

  task automatic test_reset();
    check_flag(awready, 1'b0, "awready after reset");
    check_flag(wready, 1'b0, "wready after reset");
    check_flag(arready, 1'b0, "arready after reset");
    check_flag(bvalid, 1'b0, "bvalid after reset");
    check_flag(rvalid, 1'b0, "rvalid after reset");
    check_flag(irq, 1'b0, "irq after reset");
    check_an(an, ~board_io_pkg::anode_t'(1), "anodes after reset");
    check_seg(sev_out, seg_code(4'h0), "segments after reset");
    check_led(led, '0, "led after reset");
    for (int i = 0; i < 4; i++) read_reg(board_io_pkg::reg_addr_t'(4 * i), '0, OKAY);
  endtask

  task automatic test_registers();
    board_io_pkg::reg_addr_t a;
    for (int n = 0; n < REG_ROUNDS; n++) begin
      for (int i = 0; i < 3; i++) begin
        a = board_io_pkg::reg_addr_t'(4 * i);
        write_reg(a, rand_bits(32), board_io_pkg::strb_t'(rand_bits(4)), OKAY);
        read_reg(a, model[i], OKAY);
      end
    end
  endtask

  task automatic test_events();
    board_io_pkg::word_t base;
    int n;
    int k;
    base = rand_bits(28);
    n = 3 + int'(rand_bits(3));
    k = 1 + int'(rand_bits(1));
    write_reg(`BOARD_REG_LED, rand_bits(13) | (32'd1 << `BOARD_CTRL_BIT), 4'hF, OKAY);
    write_reg(`BOARD_REG_CMP, base + k, 4'hF, OKAY);
    write_reg(`BOARD_REG_CNT, base, 4'hF, OKAY);
    wait_cycles(2);
    check_led(led, exp_led(1'b0), "led after count load");
    for (int i = 0; i < n; i++) begin
      send_pulse();
      check_led(led, exp_led(1'b0), "led after event pulse");
      check_flag(irq, exp_match() || ovf_exp, "irq after event pulse");
    end
    read_reg(`BOARD_REG_CNT, base + n, OKAY);
    // Wrap from all ones
    write_reg(`BOARD_REG_CMP, 32'd5, 4'hF, OKAY);
    write_reg(`BOARD_REG_CNT, '1, 4'hF, OKAY);
    wait_cycles(2);
    send_pulse();
    check_flag(irq, 1'b1, "irq on overflow");
    check_led(led, exp_led(1'b0), "led on overflow");
    wait_cycles(10);
    check_led(led, exp_led(1'b0), "overflow still set");
    write_reg(`BOARD_REG_CNT, 32'h10, 4'hF, OKAY);
    wait_cycles(2);
    check_flag(irq, 1'b0, "irq after count write");
    check_led(led, exp_led(1'b0), "overflow cleared");
    read_reg(`BOARD_REG_CNT, 32'h10, OKAY);
  endtask

  task automatic test_errors();
    for (int i = 0; i < 3; i++) begin
      write_reg(board_io_pkg::reg_addr_t'(5 * i + 1), rand_bits(32), 4'hF, SLVERR);
      read_reg(board_io_pkg::reg_addr_t'(3 * i + 3), '0, SLVERR);
    end
    for (int i = 0; i < 3; i++) read_reg(board_io_pkg::reg_addr_t'(4 * i), model[i], OKAY);
  endtask

  task automatic observe_scan(input board_io_pkg::word_t shown, input string what);
    board_io_pkg::anode_t prev;
    int idx;
    @(negedge clk);
    prev = an;
    while (an == prev) @(negedge clk);
    idx = digit_index(an);
    if (idx < 0) begin
      report_error({what, ": anode pattern is not one-hot-low"});
      idx = 0;
    end
    for (int step = 0; step < 8; step++) begin
      prev = an;
      while (an == prev) @(negedge clk);
      idx = (idx + 1) % 8;
      check_an(an, ~(board_io_pkg::anode_t'(1) << idx), {what, " digit order"});
      check_seg(sev_out, seg_code(shown[4*idx +: 4]), {what, " segments"});
    end
  endtask

  task automatic test_display();
    write_reg(`BOARD_REG_DISP, rand_bits(32), 4'hF, OKAY);
    write_reg(`BOARD_REG_CNT, rand_bits(32), 4'hF, OKAY);
    wait_cycles(2);
    observe_scan(model[0], "display word");
    @(posedge clk);
    debug <= 1'b1;
    observe_scan(count_exp, "event count");
    check_led(led, exp_led(1'b1), "led with debug high");
    @(posedge clk);
    debug <= 1'b0;
  endtask

  task automatic test_backpressure();
    board_io_pkg::word_t held;
    board_io_pkg::resp_t hresp;
    int hold;
    @(posedge clk);
    bready <= 1'b0;
    exp_bresp.push_back(OKAY);
    exp_bresp.push_back(OKAY);
    start_write(`BOARD_REG_DISP, rand_bits(32), 4'hF);
    while (!bvalid) @(negedge clk);
    hresp = bresp;
    hold = 2 + int'(rand_bits(3));
    fork
      start_write(`BOARD_REG_CMP, rand_bits(32), 4'hF);
      begin
        repeat (hold) begin
          @(negedge clk);
          check_flag(bvalid, 1'b1, "bvalid held");
          check_resp(bresp, hresp, "bresp held");
          check_flag(awready, 1'b0, "second write held off");
        end
        @(posedge clk);
        bready <= 1'b1;
      end
    join
    finish_write();
    // Same again on the read channel
    @(posedge clk);
    rready <= 1'b0;
    exp_rdata.push_back(model[0]);
    exp_rresp.push_back(OKAY);
    exp_rdata.push_back(model[2]);
    exp_rresp.push_back(OKAY);
    start_read(`BOARD_REG_DISP);
    while (!rvalid) @(negedge clk);
    held = rdata;
    hresp = rresp;
    hold = 2 + int'(rand_bits(3));
    fork
      start_read(`BOARD_REG_CMP);
      begin
        repeat (hold) begin
          @(negedge clk);
          check_flag(rvalid, 1'b1, "rvalid held");
          check_word(rdata, held, "rdata held");
          check_resp(rresp, hresp, "rresp held");
          check_flag(arready, 1'b0, "second read held off");
        end
        @(posedge clk);
        rready <= 1'b1;
      end
    join
    finish_read();
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  initial begin
    int mark;
    awvalid = 1'b0;
    wvalid = 1'b0;
    arvalid = 1'b0;
    bready = 1'b1;
    rready = 1'b1;
    awaddr = '0;
    araddr = '0;
    wdata = '0;
    wstrb = '0;
    event_in = 1'b0;
    debug = 1'b0;
    for (int i = 0; i < 4; i++) model[i] = '0;
    count_exp = '0;
    ovf_exp = 1'b0;
    @(posedge rst_n);
    @(negedge clk);
    mark = errors;
    test_reset();
    end_test("reset state", mark);
    mark = errors;
    test_registers();
    end_test("register access", mark);
    mark = errors;
    test_events();
    end_test("event counting", mark);
    mark = errors;
    test_errors();
    end_test("error response", mark);
    mark = errors;
    test_display();
    end_test("display scan", mark);
    mark = errors;
    test_backpressure();
    end_test("back-pressure", mark);
    if (exp_bresp.size() != 0 || exp_rresp.size() != 0) begin
      report_error("some expected bus responses never arrived");
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, a test stopped making progress", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* list.f */
+incdir+source
source/board_io_pkg.sv
source/axil_regs.sv
source/event_counter.sv
source/display_driver.sv
source/board_io_top.sv
tests/tb_clock.sv
tests/board_io_sva.sv
tests/board_io_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module board_io_tb -o board_io_sim

out=$(./obj_dir/board_io_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
  echo "run.sh: pass"
  exit 0
fi
echo "run.sh: fail"
exit 1
